// File: apbI2cTop.f
rtl/apbMapPkg.sv
rtl/i2cProtoPkg.sv
rtl/syncFifo.sv
rtl/apbRegs.sv
rtl/i2cByteEngine.sv
rtl/apbI2cTop.sv
sim/apbI2cAsserts.sv
sim/apbI2cTb.sv

// File: rtl/apbI2cTop.sv
`timescale 1ns/1ps

module apbI2cTop #(
	parameter int fifoDepth = 8,
	parameter int dividerReset = 4
)(
	input  logic PCLK,
	input  logic PRESETn,
	input  logic PSELx,
	input  logic PWRITE,
	input  logic PENABLE,
	input  logic [31:0] PADDR,
	input  logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	output logic INT_TX,
	output logic INT_RX,
	output logic sclOut,
	output logic sdaOut,
	input  logic sdaIn
);

	import apbMapPkg::*;
	import i2cProtoPkg::*;

	// APB slave to FIFOs
	logic txPush;
	i2cByte txPushData;
	logic rxPop;
	i2cByte rxHead;

	// APB slave to engine
	logic goPulse;
	logic readNotWrite;
	logic [slaveAddrWidth-1:0] slaveAddr;
	logic [byteCountWidth-1:0] byteCount;
	logic [regWidth-1:0] sclDivider;
	logic ackError;
	logic busy;

	// Engine to FIFOs
	logic txPop;
	i2cByte txHead;
	logic rxPush;
	i2cByte rxPushData;

	////////////////////////////////////////////////////////////////////////////
	// Instances
	////////////////////////////////////////////////////////////////////////////

	apbRegs #(
		.dividerReset(dividerReset)
	) apbRegs (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.PSELx(PSELx),
		.PWRITE(PWRITE),
		.PENABLE(PENABLE),
		.PADDR(PADDR),
		.PWDATA(PWDATA),
		.rxHead(rxHead),
		.ackError(ackError),
		.PRDATA(PRDATA),
		.PREADY(PREADY),
		.PSLVERR(PSLVERR),
		.txPush(txPush),
		.txPushData(txPushData),
		.rxPop(rxPop),
		.goPulse(goPulse),
		.readNotWrite(readNotWrite),
		.slaveAddr(slaveAddr),
		.byteCount(byteCount),
		.sclDivider(sclDivider)
	);

	// Empty flags are the interrupt lines
	syncFifo #(
		.payload(i2cByte),
		.fifoDepth(fifoDepth)
	) txFifo (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.push(txPush),
		.pushData(txPushData),
		.pop(txPop),
		.head(txHead),
		.empty(INT_TX),
		.full()
	);

	syncFifo #(
		.payload(i2cByte),
		.fifoDepth(fifoDepth)
	) rxFifo (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.push(rxPush),
		.pushData(rxPushData),
		.pop(rxPop),
		.head(rxHead),
		.empty(INT_RX),
		.full()
	);

	i2cByteEngine i2cByteEngine (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.goPulse(goPulse),
		.readNotWrite(readNotWrite),
		.slaveAddr(slaveAddr),
		.byteCount(byteCount),
		.sclDivider(sclDivider),
		.txHead(txHead),
		.sdaIn(sdaIn),
		.txPop(txPop),
		.rxPush(rxPush),
		.rxPushData(rxPushData),
		.ackError(ackError),
		.busy(busy),
		.sclOut(sclOut),
		.sdaOut(sdaOut)
	);

endmodule

// File: rtl/apbMapPkg.sv
package apbMapPkg;

	////////////////////////////////////////////////////////////////////////////
	// APB register map
	////////////////////////////////////////////////////////////////////////////

	// Transmit FIFO, write only
	localparam logic [31:0] txDataAddr = 32'd0;
	// Receive FIFO, read only
	localparam logic [31:0] rxDataAddr = 32'd4;
	// Transaction setup and start
	localparam logic [31:0] configAddr = 32'd8;
	// SCL half period in PCLK cycles
	localparam logic [31:0] dividerAddr = 32'd12;

	// Width of configuration and divider registers
	localparam int regWidth = 14;

	// Configuration field positions
	localparam int cfgStart = 0;
	localparam int cfgReadNotWrite = 1;
	localparam int cfgAddrLsb = 2;
	localparam int cfgAddrMsb = 8;
	localparam int cfgCountLsb = 9;
	localparam int cfgCountMsb = 13;

	// Derived field widths
	localparam int slaveAddrWidth = cfgAddrMsb - cfgAddrLsb + 1;
	localparam int byteCountWidth = cfgCountMsb - cfgCountLsb + 1;

endpackage

// File: rtl/apbRegs.sv
`timescale 1ns/1ps

module apbRegs #(
	parameter int dividerReset = 4
)(
	input  logic PCLK,
	input  logic PRESETn,
	input  logic PSELx,
	input  logic PWRITE,
	input  logic PENABLE,
	input  logic [31:0] PADDR,
	input  logic [31:0] PWDATA,
	input  i2cProtoPkg::i2cByte rxHead,
	input  logic ackError,
	output logic [31:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	output logic txPush,
	output i2cProtoPkg::i2cByte txPushData,
	output logic rxPop,
	output logic goPulse,
	output logic readNotWrite,
	output logic [apbMapPkg::slaveAddrWidth-1:0] slaveAddr,
	output logic [apbMapPkg::byteCountWidth-1:0] byteCount,
	output logic [apbMapPkg::regWidth-1:0] sclDivider
);

	import apbMapPkg::*;

	logic access;
	logic hitTx;
	logic hitRx;
	logic hitConfig;
	logic hitDivider;
	logic [regWidth-1:0] configReg;

	////////////////////////////////////////////////////////////////////////////
	// Access decode
	////////////////////////////////////////////////////////////////////////////

	// Access phase of an APB transfer
	assign access = PSELx & PENABLE;

	assign hitTx = (PADDR == txDataAddr);
	assign hitRx = (PADDR == rxDataAddr);
	assign hitConfig = (PADDR == configAddr);
	assign hitDivider = (PADDR == dividerAddr);

	// Unmapped addresses never complete
	assign PREADY = access & (hitTx | hitRx | hitConfig | hitDivider);

	// Error flag straight from the engine
	assign PSLVERR = ackError;

	// FIFO strobes, one cycle since PREADY ends the access
	assign txPush = access & PWRITE & hitTx;
	assign txPushData = PWDATA[7:0];
	assign rxPop = access & ~PWRITE & hitRx;

	// Configuration fields to the engine
	assign readNotWrite = configReg[cfgReadNotWrite];
	assign slaveAddr = configReg[cfgAddrMsb:cfgAddrLsb];
	assign byteCount = configReg[cfgCountMsb:cfgCountLsb];

	////////////////////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			configReg <= '0;
			sclDivider <= regWidth'(dividerReset);
			goPulse <= 1'b0;
		end
		else
		begin
			// Go lasts one cycle, fields already hold the new setup
			goPulse <= 1'b0;
			if (access && PWRITE && hitConfig)
			begin
				configReg <= PWDATA[regWidth-1:0];
				goPulse <= PWDATA[cfgStart];
			end
			if (access && PWRITE && hitDivider)
			begin
				sclDivider <= PWDATA[regWidth-1:0];
			end
		end
	end

	// Read mux, zero extended, write-only FIFO reads as zero
	always_comb
	begin
		PRDATA = '0;
		if (hitRx)
		begin
			PRDATA = 32'(rxHead);
		end
		else if (hitConfig)
		begin
			PRDATA = 32'(configReg);
		end
		else if (hitDivider)
		begin
			PRDATA = 32'(sclDivider);
		end
	end

endmodule

// File: rtl/i2cByteEngine.sv
`timescale 1ns/1ps

module i2cByteEngine (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic goPulse,
	input  logic readNotWrite,
	input  logic [apbMapPkg::slaveAddrWidth-1:0] slaveAddr,
	input  logic [apbMapPkg::byteCountWidth-1:0] byteCount,
	input  logic [apbMapPkg::regWidth-1:0] sclDivider,
	input  i2cProtoPkg::i2cByte txHead,
	input  logic sdaIn,
	output logic txPop,
	output logic rxPush,
	output i2cProtoPkg::i2cByte rxPushData,
	output logic ackError,
	output logic busy,
	output logic sclOut,
	output logic sdaOut
);

	import apbMapPkg::*;
	import i2cProtoPkg::*;

	localparam int bitCountWidth = $clog2(bitsPerByte);

	engineState state;
	logic [regWidth-1:0] divCount;
	logic quarterTick;
	logic [1:0] phase;
	logic bitEnd;
	logic sampleTick;
	logic [bitCountWidth-1:0] bitCount;
	logic lastBit;
	logic [byteCountWidth-1:0] bytesLeft;
	logic moreBytes;
	logic isRead;
	i2cByte shiftReg;
	logic sdaReg;
	logic sdaNext;

	assign busy = (state != idle);

	////////////////////////////////////////////////////////////////////////////
	// Bit timing
	////////////////////////////////////////////////////////////////////////////

	// Quarter bit is half the divider, so one bit is twice the divider
	// A divider below 2 ticks every cycle
	assign quarterTick = busy &&
		((divCount + regWidth'(1)) >= {1'b0, sclDivider[regWidth-1:1]});

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			divCount <= '0;
		end
		else if (!busy || quarterTick)
		begin
			divCount <= '0;
		end
		else
		begin
			divCount <= divCount + regWidth'(1);
		end
	end

	assign bitEnd = quarterTick && (phase == lastPhase);
	assign sampleTick = quarterTick && (phase == samplePhase);
	assign lastBit = (bitCount == bitCountWidth'(bitsPerByte - 1));

	// Another data byte follows this acknowledge
	assign moreBytes = !ackError &&
		((state == addrAck && bytesLeft != '0) ||
		(state == dataAck && bytesLeft != byteCountWidth'(1)));

	// Strobes toward the FIFOs
	assign txPop = bitEnd && moreBytes && !isRead;
	assign rxPush = bitEnd && isRead && (state == dataByte) && lastBit;
	assign rxPushData = shiftReg;

	////////////////////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state <= idle;
			phase <= '0;
			bitCount <= '0;
			bytesLeft <= '0;
			isRead <= 1'b0;
			ackError <= 1'b0;
		end
		else if (state == idle)
		begin
			phase <= '0;
			if (goPulse)
			begin
				state <= startBit;
				bitCount <= '0;
				bytesLeft <= byteCount;
				isRead <= readNotWrite;
				ackError <= 1'b0;
			end
		end
		else if (quarterTick)
		begin
			phase <= phase + 2'd1;
			// NACK on address or written byte, read NACK is ours
			if (phase == samplePhase && sdaIn &&
				(state == addrAck || (state == dataAck && !isRead)))
			begin
				ackError <= 1'b1;
			end
			if (phase == lastPhase)
			begin
				case (state)
					startBit:
					begin
						state <= addrByte;
					end
					addrByte, dataByte:
					begin
						// Counter wraps back to zero after the last bit
						bitCount <= bitCount + 1'b1;
						if (lastBit)
						begin
							state <= (state == addrByte) ? addrAck : dataAck;
						end
					end
					addrAck:
					begin
						state <= moreBytes ? dataByte : stopBit;
					end
					dataAck:
					begin
						bytesLeft <= bytesLeft - 1'b1;
						state <= moreBytes ? dataByte : stopBit;
					end
					default:
					begin
						state <= idle;
					end
				endcase
			end
		end
	end

	// Address and data shifter, MSB first out, LSB end in
	always_ff @(posedge PCLK)
	begin
		if (state == idle && goPulse)
		begin
			shiftReg <= {slaveAddr, readNotWrite};
		end
		else if (txPop)
		begin
			shiftReg <= txHead;
		end
		else if (sampleTick && (state == addrByte || state == dataByte))
		begin
			shiftReg <= {shiftReg[bitsPerByte-2:0], sdaIn};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus drivers
	////////////////////////////////////////////////////////////////////////////

	// START holds SCL high until the last quarter, others clock low then high
	always_comb
	begin
		case (state)
			idle: sclOut = 1'b1;
			startBit: sclOut = (phase != lastPhase);
			default: sclOut = phase[1];
		endcase
	end

	// Level for the current bit, taken once SCL has been low a quarter
	always_comb
	begin
		case (state)
			addrByte: sdaNext = shiftReg[bitsPerByte-1];
			dataByte: sdaNext = isRead ? sdaReleased : shiftReg[bitsPerByte-1];
			// ACK each read byte, NACK the last one
			dataAck: sdaNext = (isRead && bytesLeft != byteCountWidth'(1)) ?
				sdaPulled : sdaReleased;
			startBit, stopBit: sdaNext = sdaPulled;
			default: sdaNext = sdaReleased;
		endcase
	end

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			sdaReg <= sdaReleased;
		end
		else if (quarterTick && phase == drivePhase)
		begin
			sdaReg <= sdaNext;
		end
		else if (sampleTick && state == stopBit)
		begin
			// STOP, SDA rises while SCL is high
			sdaReg <= sdaReleased;
		end
	end

	assign sdaOut = sdaReg;

endmodule

// File: rtl/i2cProtoPkg.sv
package i2cProtoPkg;

	////////////////////////////////////////////////////////////////////////////
	// Byte engine sequence
	////////////////////////////////////////////////////////////////////////////

	// One state per bus phase of a transaction
	typedef enum logic [2:0] {
		idle,
		startBit,
		addrByte,
		addrAck,
		dataByte,
		dataAck,
		stopBit
	} engineState;

	// Payload of both FIFOs
	typedef logic [7:0] i2cByte;

	// Open drain levels as seen from the master
	localparam logic sdaPulled = 1'b0;
	localparam logic sdaReleased = 1'b1;

	localparam int bitsPerByte = 8;

	// Quarter-bit phases within one SCL period
	// SDA moves at end of drive phase, input sampled at end of sample phase
	localparam logic [1:0] drivePhase = 2'd0;
	localparam logic [1:0] samplePhase = 2'd2;
	localparam logic [1:0] lastPhase = 2'd3;

endpackage

// File: rtl/syncFifo.sv
`timescale 1ns/1ps

module syncFifo #(
	parameter type payload = logic [7:0],
	parameter int fifoDepth = 8
)(
	input  logic PCLK,
	input  logic PRESETn,
	input  logic push,
	input  payload pushData,
	input  logic pop,
	output payload head,
	output logic empty,
	output logic full
);

	// Pointer index bits, one more bit for wrap
	localparam int ptrWidth = $clog2(fifoDepth);

	payload mem [fifoDepth];
	logic [ptrWidth:0] wrPtr;
	logic [ptrWidth:0] rdPtr;
	logic [ptrWidth-1:0] headIdx;
	logic doPush;
	logic doPop;

	// Same index, wrap bits tell full from empty
	assign empty = (wrPtr == rdPtr);
	assign full = (wrPtr[ptrWidth] != rdPtr[ptrWidth]) &&
		(wrPtr[ptrWidth-1:0] == rdPtr[ptrWidth-1:0]);

	// Push when full and pop when empty are dropped
	assign doPush = push & ~full;
	assign doPop = pop & ~empty;

	// When empty, keep showing the entry popped last
	assign headIdx = empty ? rdPtr[ptrWidth-1:0] - 1'b1 : rdPtr[ptrWidth-1:0];
	assign head = mem[headIdx];

	// Storage
	always_ff @(posedge PCLK)
	begin
		if (doPush)
		begin
			mem[wrPtr[ptrWidth-1:0]] <= pushData;
		end
	end

	// Pointers
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (doPush)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the APB I2C master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module apbI2cTb -f apbI2cTop.f -Mdir obj_dir -o apbI2cSim

./obj_dir/apbI2cSim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q '>>> FAIL' sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

// File: sim/apbI2cAsserts.sv
`timescale 1ns/1ps

module apbI2cAsserts (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic PSELx,
	input  logic PENABLE,
	input  logic PREADY,
	input  logic PSLVERR,
	input  logic ackError,
	input  logic busy,
	input  logic txPop,
	input  logic sclOut,
	input  logic sdaOut,
	input  i2cProtoPkg::engineState state
);

	import i2cProtoPkg::*;

	////////////////////////////////////////////////////////////////////////////
	// APB side
	////////////////////////////////////////////////////////////////////////////

	// Ready only in the access phase
	readyInAccess: assert property (@(posedge PCLK) disable iff (!PRESETn)
		PREADY |-> (PSELx && PENABLE))
		else $error("PREADY high outside an APB access phase");

	// Slave error mirrors the engine flag
	errorMirror: assert property (@(posedge PCLK) disable iff (!PRESETn)
		PSLVERR == ackError)
		else $error("PSLVERR differs from the engine error flag");

	////////////////////////////////////////////////////////////////////////////
	// I2C side
	////////////////////////////////////////////////////////////////////////////

	// With SCL high, SDA moves only for START or STOP
	sdaWhileSclHigh: assert property (@(posedge PCLK) disable iff (!PRESETn)
		($changed(sdaOut) && sclOut) |-> (state == startBit || state == stopBit))
		else $error("SDA changed while SCL high outside START or STOP");

	// Transmit FIFO read only inside a transaction
	popWhileBusy: assert property (@(posedge PCLK) disable iff (!PRESETn)
		txPop |-> busy)
		else $error("Transmit FIFO popped while the engine is idle");

endmodule

bind apbI2cTop apbI2cAsserts protocolChecks (
	.PCLK(PCLK),
	.PRESETn(PRESETn),
	.PSELx(PSELx),
	.PENABLE(PENABLE),
	.PREADY(PREADY),
	.PSLVERR(PSLVERR),
	.ackError(ackError),
	.busy(busy),
	.txPop(txPop),
	.sclOut(sclOut),
	.sdaOut(sdaOut),
	.state(i2cByteEngine.state)
);

// File: sim/apbI2cTb.sv
`timescale 1ns/1ps

module apbI2cTb;

	import apbMapPkg::*;
	import i2cProtoPkg::*;

	localparam int fifoDepth = 8;
	localparam int testDivider = 4;

	// Longest transaction is START, address, eight data bytes, STOP
	localparam int maxBytes = 9;
	localparam int txnBits = 2 + maxBytes * (bitsPerByte + 1);
	localparam int txnCycles = txnBits * 2 * testDivider;
	// Five transactions plus APB traffic and reset with a wide margin
	localparam int cycleLimit = 30 * txnCycles;

	// Writable bits of the configuration and divider registers
	localparam logic [31:0] regMask = 32'((1 << regWidth) - 1);

	logic PCLK;
	logic PRESETn;
	logic PSELx;
	logic PWRITE;
	logic PENABLE;
	logic [31:0] PADDR;
	logic [31:0] PWDATA;
	logic [31:0] PRDATA;
	logic PREADY;
	logic PSLVERR;
	logic INT_TX;
	logic INT_RX;
	logic sclOut;
	logic sdaOut;
	logic sdaIn;

	// I2C slave model state
	logic slaveSda = 1'b1;
	logic busActive;
	logic sclPrev;
	logic sdaPrev;
	logic isAddr;
	logic selected;
	logic readMode;
	logic sending;
	logic masterNack;
	int bitIdx;
	i2cByte shiftIn;
	i2cByte txByte;

	// Scoreboard queues
	i2cByte expectedQ[$];
	i2cByte capturedQ[$];
	i2cByte suppliedQ[$];

	logic [31:0] lcgState = 32'hdd41_9cf2;
	string testName;
	int testCount = 0;
	int testFailures = 0;
	int checkCount = 0;
	int errorCount = 0;
	int testErrors = 0;
	int cycleCount = 0;

	// Open drain bus as the wired AND of master and slave
	assign sdaIn = sdaOut & slaveSda;

	apbI2cTop #(
		.fifoDepth(fifoDepth),
		.dividerReset(testDivider)
	) UUT (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.PSELx(PSELx),
		.PWRITE(PWRITE),
		.PENABLE(PENABLE),
		.PADDR(PADDR),
		.PWDATA(PWDATA),
		.PRDATA(PRDATA),
		.PREADY(PREADY),
		.PSLVERR(PSLVERR),
		.INT_TX(INT_TX),
		.INT_RX(INT_RX),
		.sclOut(sclOut),
		.sdaOut(sdaOut),
		.sdaIn(sdaIn)
	);

	initial
	begin
		PCLK = 1'b0;
		forever #10 PCLK = ~PCLK;
	end

	// Run limit
	always @(posedge PCLK)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// Bits 23..16 of the LCG state make the byte
	function automatic i2cByte randomByte();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[23:16];
	endfunction

	function automatic logic [31:0] configWord(input logic rnw, input logic [6:0] addr,
		input logic [4:0] count);
		logic [31:0] word;
		word = '0;
		word[cfgStart] = 1'b1;
		word[cfgReadNotWrite] = rnw;
		word[cfgAddrMsb:cfgAddrLsb] = addr;
		word[cfgCountMsb:cfgCountLsb] = count;
		return word;
	endfunction

	// Setup phase, then access phase held until PREADY
	task automatic apbAccess(input logic write, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic slvErr);
		@(posedge PCLK);
		#2;
		PSELx = 1'b1;
		PWRITE = write;
		PADDR = addr;
		PWDATA = wdata;
		PENABLE = 1'b0;
		@(posedge PCLK);
		#2;
		PENABLE = 1'b1;
		// Sample mid cycle where PRDATA and PREADY are settled
		@(negedge PCLK);
		while (!PREADY)
		begin
			@(negedge PCLK);
		end
		rdata = PRDATA;
		slvErr = PSLVERR;
		@(posedge PCLK);
		#2;
		PSELx = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
	endtask

	task automatic apbWrite(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] ignored;
		logic slvErr;
		apbAccess(1'b1, addr, data, ignored, slvErr);
	endtask

	task automatic apbRead(input logic [31:0] addr, output logic [31:0] data,
		output logic slvErr);
		apbAccess(1'b0, addr, 32'd0, data, slvErr);
	endtask

	// Full FIFO drops pushes, so only the first fifoDepth are expected
	task automatic pushBytes(input int count);
		i2cByte data;
		expectedQ.delete();
		for (int i = 0; i < count; i++)
		begin
			data = randomByte();
			if (i < fifoDepth)
			begin
				expectedQ.push_back(data);
			end
			apbWrite(txDataAddr, 32'(data));
		end
	endtask

	// Start, then wait for the engine to go busy and come back
	task automatic runTransfer(input logic rnw, input logic [6:0] addr, input logic [4:0] count);
		apbWrite(configAddr, configWord(rnw, addr, count));
		do
		begin
			@(negedge PCLK);
		end
		while (!UUT.busy);
		do
		begin
			@(negedge PCLK);
		end
		while (UUT.busy);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic checkByte(input string what, input i2cByte expected, input i2cByte actual);
		checkCount++;
		if (expected !== actual)
		begin
			$display("Mismatch in %s (%s): expected %h, actual %h",
				testName, what, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic checkWord(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual)
		begin
			$display("Mismatch in %s (%s): expected %h, actual %h",
				testName, what, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic checkFlag(input string what, input logic expected, input logic actual);
		checkCount++;
		if (expected !== actual)
		begin
			$display("Mismatch in %s (%s): expected %b, actual %b",
				testName, what, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic compareCaptured();
		checkWord("captured count", 32'(expectedQ.size()), 32'(capturedQ.size()));
		for (int i = 0; i < expectedQ.size() && i < capturedQ.size(); i++)
		begin
			checkByte("captured byte", expectedQ[i], capturedQ[i]);
		end
	endtask

	task automatic finishTest();
		testCount++;
		if (testErrors == 0)
		begin
			$display("Test %s passed", testName);
		end
		else
		begin
			testFailures++;
			$display("Test %s failed with %0d errors", testName, testErrors);
		end
		testErrors = 0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic resetDefaultsTest();
		logic [31:0] data;
		logic slvErr;
		testName = "resetDefaults";
		checkFlag("INT_TX", 1'b1, INT_TX);
		checkFlag("INT_RX", 1'b1, INT_RX);
		checkFlag("PSLVERR", 1'b0, PSLVERR);
		apbRead(configAddr, data, slvErr);
		checkWord("config", 32'd0, data);
		apbRead(dividerAddr, data, slvErr);
		checkWord("divider", 32'(testDivider), data);
		finishTest();
	endtask

	task automatic registerReadbackTest();
		logic [31:0] data;
		logic slvErr;
		testName = "registerReadback";
		// Start bit clear so no transaction runs
		apbWrite(configAddr, 32'hffff_fffe);
		apbWrite(dividerAddr, 32'h1234_5678);
		apbRead(configAddr, data, slvErr);
		checkWord("config", 32'hffff_fffe & regMask, data);
		apbRead(dividerAddr, data, slvErr);
		checkWord("divider", 32'h1234_5678 & regMask, data);
		apbWrite(dividerAddr, 32'(testDivider));
		finishTest();
	endtask

	task automatic writeTransferTest();
		logic [31:0] data;
		logic slvErr;
		testName = "writeTransfer";
		capturedQ.delete();
		pushBytes(4);
		checkFlag("INT_TX after pushes", 1'b0, INT_TX);
		runTransfer(1'b0, 7'h2a, 5'd4);
		compareCaptured();
		checkFlag("INT_TX after transfer", 1'b1, INT_TX);
		apbRead(configAddr, data, slvErr);
		checkFlag("PSLVERR", 1'b0, slvErr);
		finishTest();
	endtask

	task automatic readTransferTest();
		logic [31:0] data;
		logic slvErr;
		testName = "readTransfer";
		suppliedQ.delete();
		runTransfer(1'b1, 7'h2a, 5'd3);
		checkWord("supplied count", 32'd3, 32'(suppliedQ.size()));
		checkFlag("INT_RX before reads", 1'b0, INT_RX);
		for (int i = 0; i < 3; i++)
		begin
			apbRead(rxDataAddr, data, slvErr);
			if (i < suppliedQ.size())
			begin
				checkWord("received byte", 32'(suppliedQ[i]), data);
			end
		end
		checkFlag("INT_RX after reads", 1'b1, INT_RX);
		finishTest();
	endtask

	task automatic addressNackTest();
		logic [31:0] data;
		logic slvErr;
		testName = "addressNack";
		capturedQ.delete();
		// One byte waits in the transmit FIFO while the address is refused
		pushBytes(1);
		runTransfer(1'b0, 7'h15, 5'd1);
		apbRead(configAddr, data, slvErr);
		checkFlag("PSLVERR after NACK", 1'b1, slvErr);
		checkWord("captured count", 32'd0, 32'(capturedQ.size()));
		checkFlag("INT_TX after NACK", 1'b0, INT_TX);
		// Write to the real slave clears the error and sends the waiting byte
		runTransfer(1'b0, 7'h2a, 5'd1);
		apbRead(configAddr, data, slvErr);
		checkFlag("PSLVERR after restart", 1'b0, slvErr);
		compareCaptured();
		finishTest();
	endtask

	task automatic fifoOverflowTest();
		testName = "fifoOverflow";
		capturedQ.delete();
		pushBytes(fifoDepth + 1);
		runTransfer(1'b0, 7'h2a, 5'(fifoDepth));
		compareCaptured();
		finishTest();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// I2C slave model at 7'h2a
	////////////////////////////////////////////////////////////////////////////

	// Sampled mid cycle and drive changes only while SCL is low
	always @(negedge PCLK)
	begin
		if (!PRESETn)
		begin
			busActive = 1'b0;
			sclPrev = 1'b1;
			sdaPrev = 1'b1;
			selected = 1'b0;
			sending = 1'b0;
			slaveSda = 1'b1;
		end
		else
		begin
			if (sclPrev && sclOut && sdaPrev && !sdaIn)
			begin
				// START and the address byte follows the first SCL fall
				busActive = 1'b1;
				bitIdx = -1;
				isAddr = 1'b1;
				selected = 1'b0;
				sending = 1'b0;
				slaveSda = 1'b1;
			end
			else if (sclPrev && sclOut && !sdaPrev && sdaIn)
			begin
				// STOP
				busActive = 1'b0;
				selected = 1'b0;
				sending = 1'b0;
				slaveSda = 1'b1;
			end
			else if (busActive && !sclPrev && sclOut)
			begin
				if (bitIdx >= 0 && bitIdx < 8 && !sending)
				begin
					shiftIn = {shiftIn[6:0], sdaIn};
				end
				else if (bitIdx == 8)
				begin
					masterNack = sdaIn;
				end
			end
			else if (busActive && sclPrev && !sclOut)
			begin
				if (bitIdx < 0)
				begin
					bitIdx = 0;
				end
				else if (bitIdx < 7)
				begin
					bitIdx++;
					if (sending)
					begin
						slaveSda = txByte[7 - bitIdx];
					end
				end
				else if (bitIdx == 7)
				begin
					// Byte done with the ACK slot next
					bitIdx = 8;
					if (isAddr)
					begin
						selected = (shiftIn[7:1] == 7'h2a);
						readMode = shiftIn[0];
						slaveSda = !selected;
					end
					else if (selected && !readMode)
					begin
						capturedQ.push_back(shiftIn);
						slaveSda = 1'b0;
					end
					else
					begin
						// Master owns the ACK of a read byte
						sending = 1'b0;
						slaveSda = 1'b1;
					end
				end
				else
				begin
					bitIdx = 0;
					if (selected && readMode && (isAddr || !masterNack))
					begin
						txByte = randomByte();
						suppliedQ.push_back(txByte);
						sending = 1'b1;
						slaveSda = txByte[7];
					end
					else
					begin
						slaveSda = 1'b1;
					end
					isAddr = 1'b0;
				end
			end
			sclPrev = sclOut;
			sdaPrev = sdaIn;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		PRESETn = 1'b0;
		PSELx = 1'b0;
		PWRITE = 1'b0;
		PENABLE = 1'b0;
		PADDR = '0;
		PWDATA = '0;
		repeat (16) @(posedge PCLK);
		#2;
		PRESETn = 1'b1;
		resetDefaultsTest();
		registerReadbackTest();
		writeTransferTest();
		readTransferTest();
		addressNackTest();
		fifoOverflowTest();
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			testCount, testFailures, checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display(">>> PASS");
		end
		else
		begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule
